/* design/ctrl_cfg.svh */
//==========================================================================
// Bank controller configuration: datapath geometry, field widths,
// opcode encodings and instruction lengths
//==========================================================================

`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

//==========================================================================
// Datapath geometry
//==========================================================================
`define CTRL_N_BANKS      4   // Register banks
`define CTRL_BANK_ADDR_L  3   // Word address inside one bank
`define CTRL_MEM_ADDR_L   6   // RAM row address
`define CTRL_XBAR_SEL_L   2   // Crossbar source select per bank

//==========================================================================
// Instruction stream
//==========================================================================
`define CTRL_OPCODE_L     2
`define CTRL_INSTR_L      34  // Input word, also the longest instruction

// Opcode encodings
`define CTRL_OP_NOP       0
`define CTRL_OP_LD        1
`define CTRL_OP_ST        2
`define CTRL_OP_CP        3

// Lengths in bits, opcode included
`define CTRL_LEN_NOP      2
`define CTRL_LEN_LD       12  // opcode + en + ram addr
`define CTRL_LEN_ST       24  // LD fields + per-bank read addresses
`define CTRL_LEN_CP       34  // Three masks, read addresses, selects

`endif

/* design/ctrl_pkg.sv */
//==========================================================================
// Controller types: opcodes, instruction formats, control word and the
// opcode to length lookup
//==========================================================================

`include "ctrl_cfg.svh"

package ctrl_pkg;

  typedef enum logic [`CTRL_OPCODE_L-1:0] {
    OP_NOP = `CTRL_OP_NOP,
    OP_LD  = `CTRL_OP_LD,
    OP_ST  = `CTRL_OP_ST,
    OP_CP  = `CTRL_OP_CP
  } opcode_e;

  // Source of the bank write port
  typedef enum logic {
    WR_RAM  = 1'b0,
    WR_XBAR = 1'b1
  } wr_mode_e;

  typedef logic [`CTRL_N_BANKS-1:0]    bank_vec_t;  // One bit per bank
  typedef logic [`CTRL_BANK_ADDR_L-1:0] bank_addr_t;
  typedef logic [`CTRL_MEM_ADDR_L-1:0]  mem_addr_t;
  typedef logic [`CTRL_XBAR_SEL_L-1:0]  xbar_sel_t;

  typedef logic [$clog2(`CTRL_INSTR_L+1)-1:0]   instr_len_t;  // 0 to 34
  typedef logic [$clog2(2*`CTRL_INSTR_L+1)-1:0] fill_t;       // 0 to 68

  //========================================================================
  // Instruction formats, opcode in the low bits
  //========================================================================
  typedef struct packed {
    logic [`CTRL_INSTR_L-`CTRL_LEN_LD-1:0] pad;
    mem_addr_t                             ram_addr;
    bank_vec_t                             en;       // RAM read, bank write
    opcode_e                               opcode;
  } ld_fmt_t;

  typedef struct packed {
    logic [`CTRL_INSTR_L-`CTRL_LEN_ST-1:0] pad;
    bank_addr_t [`CTRL_N_BANKS-1:0]        rd_addr;  // Bank 0 lowest
    mem_addr_t                             ram_addr;
    bank_vec_t                             en;
    opcode_e                               opcode;
  } st_fmt_t;

  typedef struct packed {
    xbar_sel_t  [`CTRL_N_BANKS-1:0] xbar_sel;  // Source bank per destination
    bank_addr_t [`CTRL_N_BANKS-1:0] rd_addr;
    bank_vec_t                      inv_mask;
    bank_vec_t                      rd_mask;
    bank_vec_t                      wr_mask;
    opcode_e                        opcode;
  } cp_fmt_t;

  // Same word seen through each format
  typedef union packed {
    logic [`CTRL_INSTR_L-1:0] raw;
    ld_fmt_t                  ld;
    st_fmt_t                  st;
    cp_fmt_t                  cp;
  } instr_t;

  //========================================================================
  // Control word to RAM, banks and crossbar
  //========================================================================
  typedef struct packed {
    wr_mode_e                       wr_mode;
    mem_addr_t                      ram_addr;
    bank_vec_t                      ram_we;
    bank_vec_t                      ram_re;
    bank_vec_t                      reg_we;
    bank_vec_t                      reg_re;
    bank_vec_t                      reg_inv;
    bank_addr_t [`CTRL_N_BANKS-1:0] reg_rd_addr;
    xbar_sel_t  [`CTRL_N_BANKS-1:0] xbar_sel;
    bank_vec_t                      xbar_en;
  } ctrl_word_t;

  function automatic instr_len_t instr_len(input opcode_e op);
    instr_len_t len;
    case (op)
      OP_LD:   len = instr_len_t'(`CTRL_LEN_LD);
      OP_ST:   len = instr_len_t'(`CTRL_LEN_ST);
      OP_CP:   len = instr_len_t'(`CTRL_LEN_CP);
      default: len = instr_len_t'(`CTRL_LEN_NOP);
    endcase
    return len;
  endfunction

endpackage

/* design/instr_fetcher.sv */
//==========================================================================
// Instruction fetcher: two-word shift buffer that realigns variable-length
// instructions to bit 0 and hands them out one at a time
//==========================================================================

`timescale 1ns/1ps

`include "ctrl_cfg.svh"

// Buffer layout
//
//   bit 67                          fill                    bit 0
//   |      empty (zero)           |   valid bits         |
//                                 ^                      ^
//                   accepted word lands here    head instruction, shifts
//                                               out to the right
//
module instr_fetcher import ctrl_pkg::*; (
  input  logic   clk,
  input  logic   arst_n,
  input  instr_t in_word,
  input  logic   in_vld,
  output logic   in_rdy,
  output instr_t head,
  output logic   head_vld,
  input  logic   head_rdy
);

  typedef logic [2*`CTRL_INSTR_L-1:0] shreg_t;

  shreg_t     shreg_q;
  shreg_t     shreg_d;
  shreg_t     word_ext;   // Input word placed at the append point
  fill_t      fill_q;     // Valid bits from bit 0 upward
  fill_t      fill_d;
  fill_t      base;       // Fill left after this cycle's consumption
  instr_len_t head_len;
  instr_len_t shift_len;
  logic       consume;
  logic       accept;

  //========================================================================
  // Handshakes
  //========================================================================
  assign head     = instr_t'(shreg_q[`CTRL_INSTR_L-1:0]);
  assign head_len = instr_len(head.ld.opcode);  // Opcode sits at bit 0 in every format

  // Whole opcode present, then the whole instruction
  assign head_vld = (fill_q >= fill_t'(`CTRL_LEN_NOP)) &&
                    (fill_q >= fill_t'(head_len));

  // Room for a full word whatever the decoder does this cycle
  assign in_rdy = (fill_q <= fill_t'(`CTRL_INSTR_L));

  assign consume = head_vld && head_rdy;
  assign accept  = in_vld && in_rdy;

  //========================================================================
  // Shift and append
  //========================================================================
  assign shift_len = consume ? head_len : '0;
  assign base      = fill_q - fill_t'(shift_len);
  assign word_ext  = shreg_t'(in_word.raw) << base;

  always_comb begin
    shreg_d = shreg_q >> shift_len;  // Zeros come in from the top
    fill_d  = base;
    if (accept) begin
      // Bits at and above base are zero after the shift
      shreg_d = shreg_d | word_ext;
      fill_d  = base + fill_t'(`CTRL_INSTR_L);
    end
  end

  //========================================================================
  // State
  //========================================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shreg_q <= '0;
      fill_q  <= '0;
    end else begin
      shreg_q <= shreg_d;
      fill_q  <= fill_d;
    end
  end

endmodule

/* design/instr_decoder.sv */
//==========================================================================
// Instruction decoder: head instruction to control word, held in a
// valid/ready output register
//==========================================================================

`timescale 1ns/1ps

`include "ctrl_cfg.svh"

module instr_decoder import ctrl_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  instr_t     head,
  input  logic       head_vld,
  output logic       head_rdy,
  output ctrl_word_t ctrl,
  output logic       ctrl_vld,
  input  logic       ctrl_rdy
);

  ctrl_word_t dec;   // Decoded word before the output register
  logic       take;  // Head instruction consumed this cycle

  //========================================================================
  // Decode
  //========================================================================
  always_comb begin
    // Idle datapath with straight-through crossbar
    dec         = '0;
    dec.wr_mode = WR_RAM;
    for (int i = 0; i < `CTRL_N_BANKS; i++) begin
      dec.xbar_sel[i] = xbar_sel_t'(i);
    end

    case (head.ld.opcode)
      OP_LD: begin
        // RAM row into the enabled banks
        dec.ram_addr = head.ld.ram_addr;
        dec.ram_re   = head.ld.en;
        dec.reg_we   = head.ld.en;
      end

      OP_ST: begin
        dec.ram_addr    = head.st.ram_addr;
        dec.ram_we      = head.st.en;
        dec.reg_re      = head.st.en;
        dec.reg_inv     = head.st.en;  // Stored words are freed
        dec.reg_rd_addr = head.st.rd_addr;
        dec.xbar_en     = head.st.en;
      end

      OP_CP: begin
        dec.wr_mode     = WR_XBAR;
        dec.reg_we      = head.cp.wr_mask;
        dec.reg_re      = head.cp.rd_mask;
        dec.reg_inv     = head.cp.inv_mask;
        dec.reg_rd_addr = head.cp.rd_addr;
        dec.xbar_sel    = head.cp.xbar_sel;
        dec.xbar_en     = head.cp.wr_mask;  // Only written banks take the crossbar
      end

      default: ;  // NOP keeps the defaults
    endcase
  end

  //========================================================================
  // Output stage
  //========================================================================
  // Free when empty or when the held word leaves this cycle
  assign head_rdy = !ctrl_vld || ctrl_rdy;
  assign take     = head_vld && head_rdy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_vld <= 1'b0;
    end else if (head_rdy) begin
      ctrl_vld <= head_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      ctrl <= dec;
    end
  end

endmodule

/* design/bank_controller.sv */
//==========================================================================
// Bank controller front end: fetcher followed by decoder
//==========================================================================

`timescale 1ns/1ps

`include "ctrl_cfg.svh"

module bank_controller import ctrl_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  // Packed instruction stream
  input  instr_t     in_word,
  input  logic       in_vld,
  output logic       in_rdy,
  // Control words to the datapath
  output ctrl_word_t ctrl,
  output logic       ctrl_vld,
  input  logic       ctrl_rdy
);

  // Fetcher to decoder
  instr_t head;
  logic   head_vld;
  logic   head_rdy;

  instr_fetcher u_fetcher (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_word  (in_word),
    .in_vld   (in_vld),
    .in_rdy   (in_rdy),
    .head     (head),
    .head_vld (head_vld),
    .head_rdy (head_rdy)
  );

  instr_decoder u_decoder (
    .clk      (clk),
    .arst_n   (arst_n),
    .head     (head),
    .head_vld (head_vld),
    .head_rdy (head_rdy),
    .ctrl     (ctrl),
    .ctrl_vld (ctrl_vld),
    .ctrl_rdy (ctrl_rdy)
  );

endmodule

/* tests/bank_controller_props.sv */
//==========================================================================
// Bound assertions on the bank controller reset and output handshake
//==========================================================================

`timescale 1ns/1ps

module bank_controller_props import ctrl_pkg::*; (
  input logic       clk,
  input logic       arst_n,
  input logic       in_rdy,
  input ctrl_word_t ctrl,
  input logic       ctrl_vld,
  input logic       ctrl_rdy
);

  // No output word while reset is applied
  ctrl_vld_in_reset: assert property (
    @(posedge clk) !arst_n |-> !ctrl_vld
  ) else $error("ctrl_vld high during reset");

  // Held word stays put until the consumer takes it
  ctrl_hold: assert property (
    @(posedge clk) disable iff (!arst_n)
    ctrl_vld && !ctrl_rdy |=> ctrl_vld && $stable(ctrl)
  ) else $error("ctrl or ctrl_vld changed under back-pressure");

  in_rdy_after_reset: assert property (
    @(posedge clk) $rose(arst_n) |-> in_rdy  // Empty buffer
  ) else $error("in_rdy low in the first cycle after reset");

endmodule

bind bank_controller bank_controller_props u_props (
  .clk      (clk),
  .arst_n   (arst_n),
  .in_rdy   (in_rdy),
  .ctrl     (ctrl),
  .ctrl_vld (ctrl_vld),
  .ctrl_rdy (ctrl_rdy)
);

/* tests/tb_bank_controller.sv */
//==========================================================================
// Testbench for the bank controller with a random instruction stream,
// bit packing, a decode reference model, in-order checks and a watchdog
//==========================================================================

`timescale 1ns/1ps

`include "ctrl_cfg.svh"

module tb_bank_controller import ctrl_pkg::*; ();

  localparam int N_INSTR        = 200;
  localparam int RESET_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = N_INSTR * 6 + 200;
  localparam int DRIVE_DELAY    = 2;
  localparam int W              = `CTRL_INSTR_L;

  logic       clk;
  logic       arst_n;
  instr_t     in_word;
  logic       in_vld;
  logic       in_rdy;
  ctrl_word_t ctrl;
  logic       ctrl_vld;
  logic       ctrl_rdy;

  logic       stream_bits[$];  // LSB-first instruction stream
  instr_t     words[$];
  ctrl_word_t exp_q[$];
  opcode_e    op_q[$];
  int         n_expected;
  int         n_seen;

  bank_controller u_bank_controller (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_word  (in_word),
    .in_vld   (in_vld),
    .in_rdy   (in_rdy),
    .ctrl     (ctrl),
    .ctrl_vld (ctrl_vld),
    .ctrl_rdy (ctrl_rdy)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  //========================================================================
  // Reference model and stream packing
  //========================================================================
  function automatic int instr_bits(input opcode_e op);
    case (op)
      OP_LD:   return `CTRL_LEN_LD;
      OP_ST:   return `CTRL_LEN_ST;
      OP_CP:   return `CTRL_LEN_CP;
      default: return `CTRL_LEN_NOP;
    endcase
  endfunction

  // Idle datapath with a straight-through crossbar
  function automatic ctrl_word_t default_ctrl();
    ctrl_word_t c;
    c         = '0;
    c.wr_mode = WR_RAM;
    for (int i = 0; i < `CTRL_N_BANKS; i++) begin
      c.xbar_sel[i] = xbar_sel_t'(i);
    end
    return c;
  endfunction

  task automatic add_instr();
    opcode_e      op;
    bank_vec_t    en;
    bank_vec_t    wr_m;
    bank_vec_t    rd_m;
    bank_vec_t    inv_m;
    mem_addr_t    ram_addr;
    bank_addr_t   rd_addr [`CTRL_N_BANKS];
    xbar_sel_t    sel [`CTRL_N_BANKS];
    logic [W-1:0] bits;
    ctrl_word_t   exp;

    op       = opcode_e'($urandom_range(3));
    en       = bank_vec_t'($urandom);
    wr_m     = bank_vec_t'($urandom);
    rd_m     = bank_vec_t'($urandom);
    inv_m    = bank_vec_t'($urandom);
    ram_addr = mem_addr_t'($urandom);
    for (int i = 0; i < `CTRL_N_BANKS; i++) begin
      rd_addr[i] = bank_addr_t'($urandom);
      sel[i]     = xbar_sel_t'($urandom);
    end
    bits = '0;
    exp  = default_ctrl();
    case (op)
      OP_LD: begin
        bits[`CTRL_LEN_LD-1:0] = {ram_addr, en, op};
        exp.ram_addr = ram_addr;
        exp.ram_re   = en;
        exp.reg_we   = en;
      end
      OP_ST: begin
        bits[`CTRL_LEN_ST-1:0] = {rd_addr[3], rd_addr[2], rd_addr[1], rd_addr[0],
                                  ram_addr, en, op};
        exp.ram_addr = ram_addr;
        exp.ram_we   = en;
        exp.reg_re   = en;
        exp.reg_inv  = en;
        exp.xbar_en  = en;
        for (int i = 0; i < `CTRL_N_BANKS; i++) exp.reg_rd_addr[i] = rd_addr[i];
      end
      OP_CP: begin
        bits = {sel[3], sel[2], sel[1], sel[0],
                rd_addr[3], rd_addr[2], rd_addr[1], rd_addr[0],
                inv_m, rd_m, wr_m, op};
        exp.wr_mode = WR_XBAR;
        exp.reg_we  = wr_m;
        exp.reg_re  = rd_m;
        exp.reg_inv = inv_m;
        exp.xbar_en = wr_m;  // Written banks only
        for (int i = 0; i < `CTRL_N_BANKS; i++) begin
          exp.reg_rd_addr[i] = rd_addr[i];
          exp.xbar_sel[i]    = sel[i];
        end
      end
      default: bits[`CTRL_LEN_NOP-1:0] = op;
    endcase
    for (int i = 0; i < instr_bits(op); i++) stream_bits.push_back(bits[i]);
    exp_q.push_back(exp);
    op_q.push_back(op);
  endtask

  task automatic build_stream();
    int     n_words;
    int     n_pad_nops;
    instr_t word;

    for (int k = 0; k < N_INSTR; k++) add_instr();
    // Close the last word and append one zero word of NOPs
    n_words    = (stream_bits.size() + W - 1) / W + 1;
    n_pad_nops = (n_words * W - stream_bits.size()) / `CTRL_LEN_NOP;
    while (stream_bits.size() < n_words * W) stream_bits.push_back(1'b0);
    for (int i = 0; i < n_pad_nops; i++) begin
      exp_q.push_back(default_ctrl());
      op_q.push_back(OP_NOP);
    end
    for (int w = 0; w < n_words; w++) begin
      word = '0;
      for (int b = 0; b < W; b++) word.raw[b] = stream_bits[w * W + b];
      words.push_back(word);
    end
    n_expected = exp_q.size();
  endtask

  //========================================================================
  // Checks
  //========================================================================
  task automatic fail_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %b got %b", $time, what, exp, act);
      fail_run();
    end
  endtask

  task automatic check_ctrl(input int idx, input opcode_e op,
                            input ctrl_word_t exp, input ctrl_word_t act);
    if (act !== exp) begin
      $display("mismatch at %0t: control word %0d (%s) expected %h got %h",
               $time, idx, op.name(), exp, act);
      fail_run();
    end
  endtask

  //========================================================================
  // Drivers and monitor
  //========================================================================
  // Inputs change DRIVE_DELAY after each rising edge
  task automatic drive_inputs();
    int   idx;
    logic fire;
    idx = 0;
    forever begin
      ctrl_rdy = ($urandom_range(99) < 70);
      if (idx < words.size()) begin
        in_word = words[idx];
        in_vld  = ($urandom_range(99) < 70);
      end else begin
        in_vld = 1'b0;
      end
      @(negedge clk);
      fire = in_vld && in_rdy;  // Word taken at the coming edge
      @(posedge clk);
      #DRIVE_DELAY;
      if (fire) idx++;
    end
  endtask

  task automatic collect_ctrl();
    forever begin
      @(negedge clk);
      if (ctrl_vld && ctrl_rdy) begin
        if (exp_q.size() == 0) begin
          $display("Extra control word %h after the expected sequence", ctrl);
          fail_run();
        end else begin
          check_ctrl(n_seen, op_q.pop_front(), exp_q.pop_front(), ctrl);
          n_seen++;
        end
      end
    end
  endtask

  //========================================================================
  // Main sequence and watchdog
  //========================================================================
  initial begin
    void'($urandom(64));
    arst_n   = 1'b0;
    in_word  = '0;
    in_vld   = 1'b0;
    ctrl_rdy = 1'b0;
    n_seen   = 0;
    build_stream();
    repeat (RESET_CYCLES) @(posedge clk);
    check_flag("ctrl_vld in reset", 1'b0, ctrl_vld);
    #DRIVE_DELAY;
    arst_n = 1'b1;
    @(negedge clk);
    check_flag("ctrl_vld after reset", 1'b0, ctrl_vld);
    check_flag("in_rdy after reset", 1'b1, in_rdy);
    @(posedge clk);
    #DRIVE_DELAY;
    fork
      drive_inputs();
      collect_ctrl();
    join_none
    wait (n_seen == n_expected);
    repeat (20) @(posedge clk);  // Window for a stray extra word
    $display("Regression passed");
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, %0d of %0d control words seen",
             TIMEOUT_CYCLES, n_seen, n_expected);
    fail_run();
  end

endmodule

/* all.f */
+incdir+design
design/ctrl_pkg.sv
design/instr_fetcher.sv
design/instr_decoder.sv
design/bank_controller.sv
tests/bank_controller_props.sv
tests/tb_bank_controller.sv

/* Makefile */
# Verilator build and run of the bank controller regression

VERILATOR ?= verilator
TOP       ?= tb_bank_controller
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
